//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = init_fabric_tb
FILELIST  = init_fabric.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/init_fabric_tb.sv
`timescale 1ns/1ns
`include "init_params.svh"

module init_fabric_tb;

    localparam int TIMEOUT     = 5000;
    localparam int NUM         = `INIT_NUM_TABLES;
    localparam int ROWS        = 1 << `INIT_ADDR_W;
    localparam int PASS_WRITES = `INIT_BTB_DEPTH + `INIT_BHT_DEPTH +
                                 `INIT_REG_DEPTH + `INIT_MEM_DEPTH;
    localparam int C_CONTENT   = 0;
    localparam int C_COMPLETE  = 1;
    localparam int C_HOLD      = 2;
    localparam int C_TIMING    = 3;
    localparam int C_REINIT    = 4;

    logic                    clk;
    logic                    rst_i;
    logic                    init_req;
    logic                    hold;
    logic                    wr_en;
    init_cfg_pkg::table_id_e wr_table;
    logic [`INIT_ADDR_W-1:0] wr_addr;
    logic [`INIT_DATA_W-1:0] wr_data;
    logic                    init_busy;
    logic                    init_done;

    logic [`INIT_DATA_W-1:0] shadow [NUM][ROWS];  // One shadow row per DUT table
    int                      hits [NUM][ROWS];
    int                      errs [5];              // Error count per test of the pass
    int                      pass_writes;
    int                      busy_reqs;
    int                      done_rises;
    int                      cyc;
    int                      last_wr_cyc;
    logic                    hold_prev;
    logic                    done_prev;
    logic                    busy_now;
    logic [31:0]             rng;
    int                      tests_run;
    int                      tests_failed;
    int                      total_errors;
    bit                      timed_out;

    init_fabric_top UUT
    (
        .clk       (clk),
        .rst_i     (rst_i),
        .init_req  (init_req),
        .hold      (hold),
        .wr_en     (wr_en),
        .wr_table  (wr_table),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .init_busy (init_busy),
        .init_done (init_done)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int table_len(input int tbl);
        case (tbl)
            0:       return `INIT_BTB_DEPTH;
            1:       return `INIT_BHT_DEPTH;
            2:       return `INIT_REG_DEPTH;
            default: return `INIT_MEM_DEPTH;
        endcase
    endfunction

    // BTB and BHT clear, register file holds its index, memory runs 1..9 twice
    function automatic logic [`INIT_DATA_W-1:0] rule_value(input int tbl, input int idx);
        case (tbl)
            2:       return `INIT_DATA_W'(idx);
            3:       return (idx < 18) ? `INIT_DATA_W'((idx % 9) + 1) : '0;
            default: return '0;
        endcase
    endfunction

    task automatic expect_low(input string name, input logic val);
        if (val !== 1'b0)
        begin
            $display("Fail at %0t ns: %s expected 0 got %b", $time, name, val);
            errs[C_TIMING]++;
        end
    endtask

    always @(negedge clk)
    begin : watch_port
        int tbl;
        int adr;
        tbl = int'(wr_table);
        adr = int'(wr_addr);
        if (rst_i)
        begin
            expect_low("wr_en", wr_en);
            expect_low("init_busy", init_busy);
            expect_low("init_done", init_done);
        end
        else
        begin
            cyc++;
            if (wr_en)
            begin
                if (hold_prev)
                begin
                    $display("Fail at %0t ns: wr_en expected 0 got 1 after a cycle with hold high",
                             $time);
                    errs[C_HOLD]++;
                end
                if (adr >= table_len(tbl))
                begin
                    $display("Write to table %0d address %0d beyond its depth", tbl, adr);
                    errs[C_COMPLETE]++;
                end
                else
                begin
                    if (hits[tbl][adr] != 0)
                    begin
                        $display("Table %0d address %0d written more than once", tbl, adr);
                        errs[C_COMPLETE]++;
                    end
                    hits[tbl][adr]++;
                    shadow[tbl][adr] = wr_data;
                end
                pass_writes++;
                last_wr_cyc = cyc;
            end
            if (init_done && !done_prev)
            begin
                done_rises++;
                if (last_wr_cyc != cyc - 1)
                begin
                    $display("init_done rose %0d cycles after the last write instead of 1",
                             cyc - last_wr_cyc);
                    errs[C_TIMING]++;
                end
            end
            if (init_done && init_busy)
            begin
                $display("Fail at %0t ns: init_busy expected 0 got 1", $time);
                errs[C_TIMING]++;
            end
        end
        hold_prev = hold;
        done_prev = init_done;
    end

    task automatic clear_model();
        for (int t = 0; t < NUM; t++)
            for (int a = 0; a < ROWS; a++)
                hits[t][a] = 0;
        for (int i = 0; i < 5; i++)
            errs[i] = 0;
        pass_writes = 0;
        busy_reqs   = 0;
        done_rises  = 0;
    endtask

    // Random hold and busy-time init_req pulses until init_done rises
    task drive_pass(output bit ok);
        int waited;
        waited = 0;
        @(negedge clk);
        busy_now = init_busy;
        while (!init_done && waited < TIMEOUT)
        begin
            @(posedge clk);
            rng = xorshift32(rng);
            hold <= ((rng % 100) < 30);
            rng = xorshift32(rng);
            // Stop a few writes short so a pulse cannot land in SEQ_DONE
            if (busy_now && pass_writes < PASS_WRITES - 11 && (rng % 40) == 0)
            begin
                init_req <= 1'b1;
                busy_reqs++;
            end
            else
                init_req <= 1'b0;
            @(negedge clk);
            busy_now = init_busy;
            waited++;
        end
        ok = init_done;
        if (!ok)
        begin
            $display("Timeout: init_done did not rise within %0d cycles", TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic show_result(input int pass_no, input string name, input int n);
        tests_run++;
        total_errors += n;
        if (n == 0)
            $display("Pass %0d %s: ok", pass_no, name);
        else
        begin
            tests_failed++;
            $display("Pass %0d %s: failed with %0d errors", pass_no, name, n);
        end
    endtask

    task automatic report_pass(input int pass_no);
        for (int t = 0; t < NUM; t++)
            for (int a = 0; a < table_len(t); a++)
            begin
                if (hits[t][a] == 0)
                begin
                    $display("Table %0d entry %0d was never written", t, a);
                    errs[C_COMPLETE]++;
                end
                else if (shadow[t][a] !== rule_value(t, a))
                begin
                    $display("Fail at %0t ns: wr_data of table %0d entry %0d expected %0h got %0h",
                             $time, t, a, rule_value(t, a), shadow[t][a]);
                    errs[C_CONTENT]++;
                end
            end
        if (pass_writes != PASS_WRITES)
        begin
            $display("Pass wrote %0d entries instead of %0d", pass_writes, PASS_WRITES);
            errs[C_COMPLETE]++;
        end
        if (done_rises != 1)
        begin
            $display("init_done rose %0d times in the pass", done_rises);
            errs[C_TIMING]++;
        end
        if (busy_reqs == 0)
        begin
            $display("No init_req was issued while busy");
            errs[C_REINIT]++;
        end
        else if (pass_writes != PASS_WRITES)
        begin
            $display("%0d requests while busy changed the pass length", busy_reqs);
            errs[C_REINIT]++;
        end
        show_result(pass_no, "content", errs[C_CONTENT]);
        show_result(pass_no, "completeness", errs[C_COMPLETE]);
        show_result(pass_no, "back-pressure", errs[C_HOLD]);
        show_result(pass_no, "completion timing", errs[C_TIMING]);
        show_result(pass_no, "ignored init_req", errs[C_REINIT]);
    endtask

    initial
    begin
        bit ok;
        int waited;
        rst_i        = 1'b1;
        init_req     = 1'b0;
        hold         = 1'b0;
        busy_now     = 1'b0;
        hold_prev    = 1'b0;
        done_prev    = 1'b0;
        rng          = 32'd20604;
        cyc          = 0;
        last_wr_cyc  = 0;
        tests_run    = 0;
        tests_failed = 0;
        total_errors = 0;
        timed_out    = 1'b0;
        clear_model();
        repeat (2) @(posedge clk);
        @(posedge clk);
        rst_i <= 1'b0;

        drive_pass(ok);
        if (ok)
        begin
            @(posedge clk);
            report_pass(1);
            clear_model();
            @(posedge clk);
            init_req <= 1'b1;
            @(posedge clk);
            init_req <= 1'b0;
            waited = 0;
            @(negedge clk);
            while (init_done && waited < TIMEOUT)
            begin
                @(negedge clk);
                waited++;
            end
            if (init_done)
            begin
                $display("Timeout: init_req after init_done did not start a second pass");
                timed_out = 1'b1;
            end
            else
            begin
                drive_pass(ok);
                if (ok)
                begin
                    @(posedge clk);
                    report_pass(2);
                end
            end
        end

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors, timeout %0d",
                 tests_run, tests_run - tests_failed, tests_failed, total_errors, timed_out);
        if (!timed_out && total_errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- init_fabric.f
+incdir+src
src/init_cfg_pkg.sv
src/init_fsm_pkg.sv
src/walker_if.sv
src/table_walker.sv
src/write_merger.sv
src/init_sequencer.sv
src/init_fabric_top.sv
dv/init_fabric_tb.sv

//--- src/init_cfg_pkg.sv
`include "init_params.svh"

package init_cfg_pkg;

    // Encoding matches the wr_table value on the write port
    typedef enum logic [1:0]
    {
        BTB  = 2'd0,
        BHT  = 2'd1,
        REGF = 2'd2,
        DMEM = 2'd3
    } table_id_e;

    typedef enum logic [1:0]
    {
        PAT_ZERO,                       // Every entry cleared
        PAT_INDEX,                      // Entry holds its own address
        PAT_SEQ9                        // Counts 1 to 9 twice, then zero
    } fill_pat_e;

    function automatic int table_depth(table_id_e id);
        case (id)
            BTB:     return `INIT_BTB_DEPTH;
            BHT:     return `INIT_BHT_DEPTH;
            REGF:    return `INIT_REG_DEPTH;
            default: return `INIT_MEM_DEPTH;
        endcase
    endfunction

    function automatic fill_pat_e table_pattern(table_id_e id);
        case (id)
            REGF:    return PAT_INDEX;
            DMEM:    return PAT_SEQ9;
            default: return PAT_ZERO;
        endcase
    endfunction

endpackage

//--- src/init_fabric_top.sv
`timescale 1ns/1ns
`include "init_params.svh"

module init_fabric_top
(
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    init_req,
    input  logic                    hold,
    output logic                    wr_en,
    output init_cfg_pkg::table_id_e wr_table,
    output logic [`INIT_ADDR_W-1:0] wr_addr,
    output logic [`INIT_DATA_W-1:0] wr_data,
    output logic                    init_busy,
    output logic                    init_done
);

    logic start;

    walker_if walk [`INIT_NUM_TABLES] ();

    init_sequencer u_sequencer
    (
        .clk       (clk),
        .rst_i     (rst_i),
        .init_req  (init_req),
        .start     (start),
        .init_busy (init_busy),
        .init_done (init_done),
        .walk      (walk)
    );

    // Loop index doubles as the table id
    for (genvar i = 0; i < `INIT_NUM_TABLES; i++)
    begin : g_walker
        table_walker
        #(
            .TABLE_ID (init_cfg_pkg::table_id_e'(i))
        )
        u_walker
        (
            .clk   (clk),
            .rst_i (rst_i),
            .start (start),
            .port  (walk[i])
        );
    end

    write_merger u_merger
    (
        .clk      (clk),
        .rst_i    (rst_i),
        .hold     (hold),
        .walk     (walk),
        .wr_en    (wr_en),
        .wr_table (wr_table),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

endmodule

//--- src/init_fsm_pkg.sv
package init_fsm_pkg;

    // Reset lands in SEQ_IDLE and a pass starts from it directly
    typedef enum logic [1:0]
    {
        SEQ_IDLE,
        SEQ_START,
        SEQ_RUN,
        SEQ_DONE
    } seq_state_e;

    typedef enum logic [1:0]
    {
        WALK_IDLE,
        WALK_REQ,
        WALK_FIN
    } walk_state_e;

endpackage

//--- src/init_params.svh
`ifndef INIT_PARAMS_SVH
`define INIT_PARAMS_SVH

// Tables written by one initialization pass
`define INIT_NUM_TABLES 4

// Shared write port sizing
`define INIT_ADDR_W 8
`define INIT_DATA_W 40                  // BTB entries are the widest

// Entry counts per table
`define INIT_BTB_DEPTH 256
`define INIT_BHT_DEPTH 256
`define INIT_REG_DEPTH 32
`define INIT_MEM_DEPTH 27               // Data memory preload words

`endif

//--- src/init_sequencer.sv
`timescale 1ns/1ns
`include "init_params.svh"

module init_sequencer
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      init_req,
    output logic      start,
    output logic      init_busy,
    output logic      init_done,
    walker_if.monitor walk [`INIT_NUM_TABLES]
);

    init_fsm_pkg::seq_state_e    state_q;
    logic [`INIT_NUM_TABLES-1:0] fin_vec;

    for (genvar i = 0; i < `INIT_NUM_TABLES; i++)
    begin : g_fin
        assign fin_vec[i] = walk[i].finished;
    end

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            state_q <= init_fsm_pkg::SEQ_IDLE;
        end
        else
        begin
            case (state_q)
                init_fsm_pkg::SEQ_IDLE, init_fsm_pkg::SEQ_START:
                begin
                    state_q <= init_fsm_pkg::SEQ_RUN;
                end
                init_fsm_pkg::SEQ_RUN:
                begin
                    // Last flag rises the cycle its final entry is on the port
                    if (&fin_vec)
                        state_q <= init_fsm_pkg::SEQ_DONE;
                end
                default:
                begin
                    if (init_req)
                        state_q <= init_fsm_pkg::SEQ_START;
                end
            endcase
        end
    end

    // Tables are unknown after reset, so leaving reset kicks a pass on its own
    assign start     = (state_q == init_fsm_pkg::SEQ_IDLE) ||
                       (state_q == init_fsm_pkg::SEQ_START);
    assign init_busy = (state_q == init_fsm_pkg::SEQ_RUN);
    assign init_done = (state_q == init_fsm_pkg::SEQ_DONE);

    // A start pulse has to pull every walker out of its finished state
    a_start_clears_fin: assert property (@(posedge clk) disable iff (rst_i)
        start |=> !start && (fin_vec == '0));

endmodule

//--- src/table_walker.sv
`timescale 1ns/1ns
`include "init_params.svh"

module table_walker
#(
    parameter init_cfg_pkg::table_id_e TABLE_ID = init_cfg_pkg::BTB
)
(
    input  logic     clk,
    input  logic     rst_i,
    input  logic     start,
    walker_if.walker port
);

    localparam int DEPTH = init_cfg_pkg::table_depth(TABLE_ID);
    localparam init_cfg_pkg::fill_pat_e PATTERN = init_cfg_pkg::table_pattern(TABLE_ID);
    localparam logic [`INIT_ADDR_W-1:0] LAST_ADDR = `INIT_ADDR_W'(DEPTH - 1);
    localparam int SEQ9_SPAN = 18;      // Two full runs of 1..9, zeros after

    init_fsm_pkg::walk_state_e state_q;
    logic [`INIT_ADDR_W-1:0]   addr_q;
    logic [3:0]                mod9_q;  // Tracks addr_q mod 9
    logic [`INIT_DATA_W-1:0]   seq9_val;

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            state_q <= init_fsm_pkg::WALK_IDLE;
            addr_q  <= '0;
            mod9_q  <= '0;
        end
        else
        begin
            case (state_q)
                init_fsm_pkg::WALK_IDLE, init_fsm_pkg::WALK_FIN:
                begin
                    if (start)
                    begin
                        state_q <= init_fsm_pkg::WALK_REQ;
                        addr_q  <= '0;
                        mod9_q  <= '0;
                    end
                end
                init_fsm_pkg::WALK_REQ:
                begin
                    // The merger takes the entry at this edge
                    if (port.grant)
                    begin
                        if (addr_q == LAST_ADDR)
                        begin
                            state_q <= init_fsm_pkg::WALK_FIN;
                        end
                        else
                        begin
                            addr_q <= addr_q + 1'b1;
                            mod9_q <= (mod9_q == 4'd8) ? 4'd0 : mod9_q + 4'd1;
                        end
                    end
                end
                default:
                begin
                    state_q <= init_fsm_pkg::WALK_IDLE;
                end
            endcase
        end
    end

    always_comb
    begin
        seq9_val = '0;
        if (int'(addr_q) < SEQ9_SPAN)
            seq9_val = `INIT_DATA_W'(mod9_q) + `INIT_DATA_W'(1);

        case (PATTERN)
            init_cfg_pkg::PAT_INDEX: port.data = `INIT_DATA_W'(addr_q);
            init_cfg_pkg::PAT_SEQ9:  port.data = seq9_val;
            default:                 port.data = '0;
        endcase
    end

    assign port.req      = (state_q == init_fsm_pkg::WALK_REQ);
    assign port.addr     = addr_q;
    assign port.finished = (state_q == init_fsm_pkg::WALK_FIN);

    // The counter must stop on the last entry and never offer one past the table
    a_addr_in_range: assert property (@(posedge clk) disable iff (rst_i)
        port.req |-> (int'(port.addr) < DEPTH));

endmodule

//--- src/walker_if.sv
`timescale 1ns/1ns
`include "init_params.svh"

interface walker_if;

    logic                    req;       // Entry pending
    logic                    grant;     // Entry taken at this edge
    logic [`INIT_ADDR_W-1:0] addr;
    logic [`INIT_DATA_W-1:0] data;
    logic                    finished;

    modport walker
    (
        output req, addr, data, finished,
        input  grant
    );

    modport merger
    (
        input  req, addr, data,
        output grant
    );

    // The sequencer only needs to know when a table is complete
    modport monitor
    (
        input finished
    );

endinterface

//--- src/write_merger.sv
`timescale 1ns/1ns
`include "init_params.svh"

module write_merger
(
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    hold,
    walker_if.merger                walk [`INIT_NUM_TABLES],
    output logic                    wr_en,
    output init_cfg_pkg::table_id_e wr_table,
    output logic [`INIT_ADDR_W-1:0] wr_addr,
    output logic [`INIT_DATA_W-1:0] wr_data
);

    localparam int NUM   = `INIT_NUM_TABLES;
    localparam int SEL_W = $clog2(NUM);

    logic [NUM-1:0]          req_vec;
    logic [NUM-1:0]          grant_vec;
    logic [`INIT_ADDR_W-1:0] addr_arr [NUM];
    logic [`INIT_DATA_W-1:0] data_arr [NUM];
    logic [SEL_W-1:0]        last_q;    // Walker granted most recently
    logic [SEL_W-1:0]        sel;
    logic [SEL_W-1:0]        cand;
    logic                    found;

    // Interface arrays only take constant indices, so flatten them here
    for (genvar i = 0; i < NUM; i++)
    begin : g_flat
        assign req_vec[i]    = walk[i].req;
        assign addr_arr[i]   = walk[i].addr;
        assign data_arr[i]   = walk[i].data;
        assign walk[i].grant = grant_vec[i];
    end

    // Search starts one past the last winner so every table gets its turn
    always_comb
    begin
        grant_vec = '0;
        sel       = last_q;
        cand      = last_q;
        found     = 1'b0;
        for (int off = 1; off <= NUM; off++)
        begin
            cand = SEL_W'((int'(last_q) + off) % NUM);
            if (!found && req_vec[cand])
            begin
                sel   = cand;
                found = 1'b1;
            end
        end
        if (found && !hold)
            grant_vec[sel] = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            wr_en  <= 1'b0;
            last_q <= SEL_W'(NUM - 1);  // BTB wins the first slot
        end
        else
        begin
            wr_en <= |grant_vec;
            if (|grant_vec)
                last_q <= sel;
        end
    end

    always_ff @(posedge clk)
    begin
        if (|grant_vec)
        begin
            wr_table <= init_cfg_pkg::table_id_e'(sel);
            wr_addr  <= addr_arr[sel];
            wr_data  <= data_arr[sel];
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (rst_i)
        $onehot0(grant_vec));

    a_grant_to_req: assert property (@(posedge clk) disable iff (rst_i)
        (grant_vec & ~req_vec) == '0);

endmodule
